/* design/dec_pkg.sv */
// 8b/10b decoder common definitions
package dec_pkg;

    // --------------------
    // widths
    localparam int SYM_W  = 10;
    localparam int BYTE_W = 8;
    localparam int SUB6_W = 6;
    localparam int SUB4_W = 4;
    localparam int CLS_W  = 3;

    // --------------------
    // types
    typedef logic [SYM_W-1:0]        symbol_t;  // abcdei fghj
    typedef logic [BYTE_W-1:0]       byte_t;    // HGF EDCBA
    typedef logic [SUB6_W-1:0]       sub6_t;
    typedef logic [SUB4_W-1:0]       sub4_t;
    typedef logic [SUB6_W-2:0]       edcba_t;
    typedef logic [SUB4_W-2:0]       hgf_t;
    typedef logic [CLS_W-1:0]        rd_cls_t;

    // --------------------
    // disparity class of one sub-block
    localparam rd_cls_t CLS_NEUTRAL  = 3'd0;  // balanced and keeps rd
    localparam rd_cls_t CLS_FROM_NEG = 3'd1;  // more ones take rd- to rd+
    localparam rd_cls_t CLS_FROM_POS = 3'd2;  // more zeros take rd+ to rd-
    localparam rd_cls_t CLS_HOLD_NEG = 3'd3;  // 111000 / 1100 at rd- only
    localparam rd_cls_t CLS_HOLD_POS = 3'd4;  // 000111 / 0011 at rd+ only

    // K28 6-bit forms
    localparam sub6_t K28_NEG = 6'b001111;
    localparam sub6_t K28_POS = 6'b110000;

    // running disparity bit
    localparam logic RD_NEG = 1'b0;
    localparam logic RD_POS = 1'b1;

endpackage

/* design/dec_6b5b.sv */
// 6b/5b sub-block decoder
`timescale 1ns/100ps

module dec_6b5b import dec_pkg::*; (
    input  sub6_t   sub6,
    output edcba_t  edcba,
    output rd_cls_t cls6,
    output logic    k28,
    output logic    err6
);

    // the inverted K28 form; its balanced fghj codes read complemented
    assign k28 = (sub6 == K28_POS);

    always_comb begin
        edcba = '0;
        cls6  = CLS_NEUTRAL;
        err6  = 1'b0;
        case (sub6)
            6'b100111: {edcba, cls6} = {5'd0,  CLS_FROM_NEG};
            6'b011000: {edcba, cls6} = {5'd0,  CLS_FROM_POS};
            6'b011101: {edcba, cls6} = {5'd1,  CLS_FROM_NEG};
            6'b100010: {edcba, cls6} = {5'd1,  CLS_FROM_POS};
            6'b101101: {edcba, cls6} = {5'd2,  CLS_FROM_NEG};
            6'b010010: {edcba, cls6} = {5'd2,  CLS_FROM_POS};
            6'b110001: {edcba, cls6} = {5'd3,  CLS_NEUTRAL};
            6'b110101: {edcba, cls6} = {5'd4,  CLS_FROM_NEG};
            6'b001010: {edcba, cls6} = {5'd4,  CLS_FROM_POS};
            6'b101001: {edcba, cls6} = {5'd5,  CLS_NEUTRAL};
            6'b011001: {edcba, cls6} = {5'd6,  CLS_NEUTRAL};
            6'b111000: {edcba, cls6} = {5'd7,  CLS_HOLD_NEG};  // balanced but rd- only
            6'b000111: {edcba, cls6} = {5'd7,  CLS_HOLD_POS};
            6'b111001: {edcba, cls6} = {5'd8,  CLS_FROM_NEG};
            6'b000110: {edcba, cls6} = {5'd8,  CLS_FROM_POS};
            6'b100101: {edcba, cls6} = {5'd9,  CLS_NEUTRAL};
            6'b010101: {edcba, cls6} = {5'd10, CLS_NEUTRAL};
            6'b110100: {edcba, cls6} = {5'd11, CLS_NEUTRAL};
            6'b001101: {edcba, cls6} = {5'd12, CLS_NEUTRAL};
            6'b101100: {edcba, cls6} = {5'd13, CLS_NEUTRAL};
            6'b011100: {edcba, cls6} = {5'd14, CLS_NEUTRAL};
            6'b010111: {edcba, cls6} = {5'd15, CLS_FROM_NEG};
            6'b101000: {edcba, cls6} = {5'd15, CLS_FROM_POS};
            6'b011011: {edcba, cls6} = {5'd16, CLS_FROM_NEG};
            6'b100100: {edcba, cls6} = {5'd16, CLS_FROM_POS};
            6'b100011: {edcba, cls6} = {5'd17, CLS_NEUTRAL};
            6'b010011: {edcba, cls6} = {5'd18, CLS_NEUTRAL};
            6'b110010: {edcba, cls6} = {5'd19, CLS_NEUTRAL};
            6'b001011: {edcba, cls6} = {5'd20, CLS_NEUTRAL};
            6'b101010: {edcba, cls6} = {5'd21, CLS_NEUTRAL};
            6'b011010: {edcba, cls6} = {5'd22, CLS_NEUTRAL};
            6'b111010: {edcba, cls6} = {5'd23, CLS_FROM_NEG};
            6'b000101: {edcba, cls6} = {5'd23, CLS_FROM_POS};
            6'b110011: {edcba, cls6} = {5'd24, CLS_FROM_NEG};
            6'b001100: {edcba, cls6} = {5'd24, CLS_FROM_POS};
            6'b100110: {edcba, cls6} = {5'd25, CLS_NEUTRAL};
            6'b010110: {edcba, cls6} = {5'd26, CLS_NEUTRAL};
            6'b110110: {edcba, cls6} = {5'd27, CLS_FROM_NEG};
            6'b001001: {edcba, cls6} = {5'd27, CLS_FROM_POS};
            6'b001110: {edcba, cls6} = {5'd28, CLS_NEUTRAL};
            6'b101110: {edcba, cls6} = {5'd29, CLS_FROM_NEG};
            6'b010001: {edcba, cls6} = {5'd29, CLS_FROM_POS};
            6'b011110: {edcba, cls6} = {5'd30, CLS_FROM_NEG};
            6'b100001: {edcba, cls6} = {5'd30, CLS_FROM_POS};
            6'b101011: {edcba, cls6} = {5'd31, CLS_FROM_NEG};
            6'b010100: {edcba, cls6} = {5'd31, CLS_FROM_POS};
            // control only
            K28_NEG:   {edcba, cls6} = {5'd28, CLS_FROM_NEG};
            K28_POS:   {edcba, cls6} = {5'd28, CLS_FROM_POS};
            default: begin
                err6 = 1'b1;  // not a legal abcdei code
            end
        endcase
    end

endmodule

/* design/dec_4b3b.sv */
// 4b/3b sub-block decoder
`timescale 1ns/100ps

module dec_4b3b import dec_pkg::*; (
    input  sub4_t   sub4,
    input  logic    k28,
    output hgf_t    hgf,
    output rd_cls_t cls4,
    output logic    err4
);

    hgf_t    hgf_d;  // data reading of fghj

    // --------------------
    // data table with both .7 forms accepted
    always_comb begin
        hgf_d = '0;
        cls4  = CLS_NEUTRAL;
        err4  = 1'b0;
        case (sub4)
            4'b1011: {hgf_d, cls4} = {3'd0, CLS_FROM_NEG};
            4'b0100: {hgf_d, cls4} = {3'd0, CLS_FROM_POS};
            4'b1001: {hgf_d, cls4} = {3'd1, CLS_NEUTRAL};
            4'b0101: {hgf_d, cls4} = {3'd2, CLS_NEUTRAL};
            4'b1100: {hgf_d, cls4} = {3'd3, CLS_HOLD_NEG};
            4'b0011: {hgf_d, cls4} = {3'd3, CLS_HOLD_POS};
            4'b1101: {hgf_d, cls4} = {3'd4, CLS_FROM_NEG};
            4'b0010: {hgf_d, cls4} = {3'd4, CLS_FROM_POS};
            4'b1010: {hgf_d, cls4} = {3'd5, CLS_NEUTRAL};
            4'b0110: {hgf_d, cls4} = {3'd6, CLS_NEUTRAL};
            4'b1110: {hgf_d, cls4} = {3'd7, CLS_FROM_NEG};  // primary
            4'b0001: {hgf_d, cls4} = {3'd7, CLS_FROM_POS};
            4'b0111: {hgf_d, cls4} = {3'd7, CLS_FROM_NEG};  // alternate
            4'b1000: {hgf_d, cls4} = {3'd7, CLS_FROM_POS};
            default: begin
                err4 = 1'b1;
            end
        endcase
    end

    // --------------------
    // control versions of .1 .2 .5 .6
    // behind 110000 these four come complemented, so
    // 0110 is .1, 1010 is .2, 0101 is .5 and 1001 is .6
    always_comb begin
        hgf = hgf_d;
        if (k28 && !err4 && cls4 == CLS_NEUTRAL) begin
            hgf = ~hgf_d;  // 1<->6, 2<->5
        end
    end

endmodule

/* design/symbol_stage.sv */
// symbol pipeline stage
`timescale 1ns/100ps

module symbol_stage import dec_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  sub6_t   sub6_raw,
    input  sub4_t   sub4_raw,
    input  edcba_t  edcba,
    input  hgf_t    hgf,
    input  rd_cls_t cls6,
    input  rd_cls_t cls4,
    input  logic    k28,
    input  logic    err6,
    input  logic    err4,
    output byte_t   s_byte,
    output logic    s_k,
    output logic    s_code_err,
    output rd_cls_t s_cls6,
    output rd_cls_t s_cls4,
    output logic    s_valid
);

    logic sym_err;
    logic is_k28;
    logic is_kx7;

    assign sym_err = err6 | err4;
    assign is_k28  = k28 | (sub6_raw == K28_NEG);  // either K28 form

    // --------------------
    // K23.7 K27.7 K29.7 K30.7
    // these use the alternate .7 behind the D23/27/29/30 codes,
    // which data never does
    always_comb begin
        case (sub6_raw)
            6'b111010, 6'b000101,  // 23
            6'b110110, 6'b001001,  // 27
            6'b101110, 6'b010001,  // 29
            6'b011110, 6'b100001: begin  // 30
                is_kx7 = (sub4_raw == 4'b0111) || (sub4_raw == 4'b1000);
            end
            default: begin
                is_kx7 = 1'b0;
            end
        endcase
    end

    // --------------------
    // control flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid    <= 1'b0;
            s_k        <= 1'b0;
            s_code_err <= 1'b0;
        end else if (enable) begin
            s_valid    <= 1'b1;
            s_k        <= ~sym_err & (is_k28 | is_kx7);
            s_code_err <= sym_err;
        end else begin
            s_valid    <= 1'b0;
            s_k        <= 1'b0;
            s_code_err <= 1'b0;
        end
    end

    // byte and classes
    always_ff @(posedge clk) begin
        if (enable) begin
            s_byte <= {hgf, edcba};
            s_cls6 <= cls6;
            s_cls4 <= cls4;
        end else begin
            s_byte <= '0;
            s_cls6 <= CLS_NEUTRAL;  // idle slot moves nothing
            s_cls4 <= CLS_NEUTRAL;
        end
    end

endmodule

/* design/disparity_check.sv */
// running disparity checker
`timescale 1ns/100ps

module disparity_check import dec_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rd_load,
    input  logic    rd_init,
    input  byte_t   s_byte,
    input  logic    s_k,
    input  logic    s_code_err,
    input  rd_cls_t s_cls6,
    input  rd_cls_t s_cls4,
    input  logic    s_valid,
    output byte_t   data_out,
    output logic    k_char,
    output logic    code_err,
    output logic    rd_err,
    output logic    error,
    output logic    rd,
    output logic    valid
);

    logic [1:0] step6;   // {illegal, rd after 6b}
    logic [1:0] step4;   // {illegal, rd after 4b}
    logic       rd_nxt;
    logic       rd_bad;

    // judge one sub-block class against the disparity it meets
    function automatic logic [1:0] rd_step(input logic rd_in, input rd_cls_t cls);
        logic ill;
        logic rd_out;
        ill    = 1'b0;
        rd_out = rd_in;
        case (cls)
            CLS_FROM_NEG: begin
                ill    = (rd_in != RD_NEG);
                rd_out = RD_POS;
            end
            CLS_FROM_POS: begin
                ill    = (rd_in != RD_POS);
                rd_out = RD_NEG;
            end
            CLS_HOLD_NEG: ill = (rd_in != RD_NEG);
            CLS_HOLD_POS: ill = (rd_in != RD_POS);
            default:      ill = 1'b0;  // neutral or errored block
        endcase
        return {ill, rd_out};
    endfunction

    always_comb begin
        step6  = rd_step(rd, s_cls6);
        step4  = rd_step(step6[0], s_cls4);  // 4b sees the intermediate rd
        rd_nxt = step4[0];
        rd_bad = step6[1] | step4[1];
    end

    // --------------------
    // disparity register where load wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd <= RD_NEG;
        end else if (rd_load) begin
            rd <= rd_init;
        end else if (s_valid) begin
            rd <= rd_nxt;
        end
    end

    // outputs quiet while no symbol
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= 1'b0;
            data_out <= '0;
            k_char   <= 1'b0;
            code_err <= 1'b0;
            rd_err   <= 1'b0;
            error    <= 1'b0;
        end else begin
            valid    <= s_valid;
            data_out <= s_valid ? s_byte : '0;
            k_char   <= s_valid & s_k;
            code_err <= s_valid & s_code_err;
            rd_err   <= s_valid & rd_bad;
            error    <= s_valid & (s_code_err | rd_bad);
        end
    end

endmodule

/* design/dec_8b10b_top.sv */
// 8b/10b decoder top
`timescale 1ns/100ps

module dec_8b10b_top import dec_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  symbol_t symbol_in,
    input  logic    rd_load,
    input  logic    rd_init,
    output byte_t   data_out,
    output logic    k_char,
    output logic    code_err,
    output logic    rd_err,
    output logic    error,
    output logic    rd,
    output logic    valid
);

    // lookup results
    edcba_t  edcba;
    hgf_t    hgf;
    rd_cls_t cls6;
    rd_cls_t cls4;
    logic    k28;
    logic    err6;
    logic    err4;

    // stage to checker
    byte_t   s_byte;
    logic    s_k;
    logic    s_code_err;
    rd_cls_t s_cls6;
    rd_cls_t s_cls4;
    logic    s_valid;

    dec_6b5b i_dec6 (
        .sub6  (symbol_in[9:4]),  // abcdei
        .edcba (edcba),
        .cls6  (cls6),
        .k28   (k28),
        .err6  (err6)
    );

    dec_4b3b i_dec4 (
        .sub4 (symbol_in[3:0]),   // fghj
        .k28  (k28),
        .hgf  (hgf),
        .cls4 (cls4),
        .err4 (err4)
    );

    symbol_stage i_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .sub6_raw   (symbol_in[9:4]),
        .sub4_raw   (symbol_in[3:0]),
        .edcba      (edcba),
        .hgf        (hgf),
        .cls6       (cls6),
        .cls4       (cls4),
        .k28        (k28),
        .err6       (err6),
        .err4       (err4),
        .s_byte     (s_byte),
        .s_k        (s_k),
        .s_code_err (s_code_err),
        .s_cls6     (s_cls6),
        .s_cls4     (s_cls4),
        .s_valid    (s_valid)
    );

    disparity_check i_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_load    (rd_load),
        .rd_init    (rd_init),
        .s_byte     (s_byte),
        .s_k        (s_k),
        .s_code_err (s_code_err),
        .s_cls6     (s_cls6),
        .s_cls4     (s_cls4),
        .s_valid    (s_valid),
        .data_out   (data_out),
        .k_char     (k_char),
        .code_err   (code_err),
        .rd_err     (rd_err),
        .error      (error),
        .rd         (rd),
        .valid      (valid)
    );

endmodule

/* verification/tb_ref_codec.svh */
// 8b/10b reference codec
`ifndef TB_REF_CODEC_SVH
`define TB_REF_CODEC_SVH

typedef struct packed {
    logic  rd_next;
    logic  rd_err;
    logic  code_err;
    logic  k;
    byte_t data;
} exp_t;

// abcdei at rd- with D0 first
localparam logic [191:0] TBL6 = {
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
// fghj at rd- from .0 up with primary .7
localparam logic [31:0] TBL4 = {4'b1011, 4'b1001, 4'b0101, 4'b1100,
                                4'b1101, 4'b1010, 4'b0110, 4'b1110};

function automatic sub6_t enc6(input logic [4:0] x, input logic rd_in);
    sub6_t c;
    c = TBL6[6*(31-x) +: 6];
    if (rd_in == RD_POS && ($countones(c) != 3 || c == 6'b111000)) c = ~c;
    return c;
endfunction

function automatic sub4_t enc4(input logic [2:0] y, input logic rd_in);
    sub4_t c;
    c = TBL4[4*(7-y) +: 4];
    if (rd_in == RD_POS && ($countones(c) != 2 || c == 4'b1100)) c = ~c;
    return c;
endfunction

// disparity after a block of 2*half bits with n ones
function automatic logic rd_after(input logic rd_in, input int n, input int half);
    if (n > half) return RD_POS;
    if (n < half) return RD_NEG;
    return rd_in;
endfunction

function automatic rd_cls_t block_class(input int n, input int half, input logic hold_n,
                                        input logic hold_p);
    if (n > half) return CLS_FROM_NEG;
    if (n < half) return CLS_FROM_POS;
    if (hold_n) return CLS_HOLD_NEG;
    if (hold_p) return CLS_HOLD_POS;
    return CLS_NEUTRAL;
endfunction

// {illegal, new rd}
function automatic logic [1:0] apply_class(input logic rd_in, input rd_cls_t c);
    logic ok;
    logic rd_out;
    ok     = 1'b1;
    rd_out = rd_in;
    if (c == CLS_FROM_NEG || c == CLS_HOLD_NEG) ok = (rd_in == RD_NEG);
    if (c == CLS_FROM_POS || c == CLS_HOLD_POS) ok = (rd_in == RD_POS);
    if (c == CLS_FROM_NEG) rd_out = RD_POS;
    if (c == CLS_FROM_POS) rd_out = RD_NEG;
    return {~ok, rd_out};
endfunction

// {new rd, symbol}
function automatic logic [10:0] enc_8b10b(input byte_t b, input logic k, input logic rd_in);
    logic [4:0] x;
    logic [2:0] y;
    sub6_t      s6;
    sub4_t      s4;
    logic       rd_mid;
    logic       alt;
    x      = b[4:0];
    y      = b[7:5];
    s6     = (k && x == 28) ? ((rd_in == RD_NEG) ? K28_NEG : K28_POS) : enc6(x, rd_in);
    rd_mid = rd_after(rd_in, $countones(s6), 3);
    alt    = (y == 7) && (k || (rd_mid == RD_NEG && (x == 17 || x == 18 || x == 20)) ||
                               (rd_mid == RD_POS && (x == 11 || x == 13 || x == 14)));
    s4     = alt ? ((rd_mid == RD_NEG) ? 4'b0111 : 4'b1000) : enc4(y, rd_mid);
    if (k && x == 28 && rd_mid == RD_NEG && (y == 1 || y == 2 || y == 5 || y == 6)) begin
        s4 = ~s4;  // balanced K28 fghj inverted behind 110000
    end
    return {rd_after(rd_mid, $countones(s4), 2), s6, s4};
endfunction

function automatic exp_t exp_decode(input symbol_t sym, input logic rd_in);
    exp_t       e;
    sub6_t      s6;
    sub4_t      s4;
    logic       ok6;
    logic       ok4;
    logic       alt7;
    logic       is_k28;
    logic [4:0] x6;
    logic [2:0] y4;
    rd_cls_t    c6;
    rd_cls_t    c4;
    logic [1:0] st6;
    logic [1:0] st4;
    int         i;
    s6 = sym[9:4];
    s4 = sym[3:0];
    {ok6, ok4, x6, y4} = '0;
    for (i = 0; i < 64; i++) begin  // search every sub-block code at both disparities
        if (enc6(i[5:1], i[0]) == s6) {ok6, x6} = {1'b1, i[5:1]};
        if (i < 16 && enc4(i[3:1], i[0]) == s4) {ok4, y4} = {1'b1, i[3:1]};
    end
    is_k28 = (s6 == K28_NEG) || (s6 == K28_POS);
    alt7   = (s4 == 4'b0111) || (s4 == 4'b1000);
    if (is_k28) {ok6, x6} = {1'b1, 5'd28};
    if (alt7) {ok4, y4} = {1'b1, 3'd7};
    c6 = ok6 ? block_class($countones(s6), 3, s6 == 6'b111000, s6 == 6'b000111) : CLS_NEUTRAL;
    c4 = ok4 ? block_class($countones(s4), 2, s4 == 4'b1100, s4 == 4'b0011) : CLS_NEUTRAL;
    if (s6 == K28_POS && ok4 && c4 == CLS_NEUTRAL) y4 = ~y4;
    st6        = apply_class(rd_in, c6);
    st4        = apply_class(st6[0], c4);  // 4b judged after the 6b move
    e.data     = {y4, x6};
    e.code_err = ~(ok6 & ok4);
    e.k        = ok6 & ok4 & (is_k28 |
                 (alt7 & (x6 == 23 || x6 == 27 || x6 == 29 || x6 == 30)));
    e.rd_err   = st6[1] | st4[1];
    e.rd_next  = st4[0];
    return e;
endfunction

`endif

/* verification/tb_dec_8b10b.sv */
// 8b/10b decoder testbench
`timescale 1ns/100ps

module tb_dec_8b10b import dec_pkg::*; ();

    localparam int N_RANDOM    = 300;
    localparam int N_SYMBOLS   = N_RANDOM + 48 + 4 + 8 + 3;  // most symbols ever issued
    localparam int CYCLE_LIMIT = 2 * N_SYMBOLS + 50;
    localparam logic [95:0] K_BYTES = {8'hFE, 8'hFD, 8'hFB, 8'hF7, 8'hFC, 8'hDC,
                                       8'hBC, 8'h9C, 8'h7C, 8'h5C, 8'h3C, 8'h1C};
    localparam logic [31:0] BAD_RD_BYTES = {8'h38, 8'h1B, 8'h0F, 8'h00};

    logic    clk = 1'b0;
    logic    rst_n;
    logic    enable;
    symbol_t symbol_in;
    logic    rd_load;
    logic    rd_init;
    byte_t   data_out;
    logic    k_char;
    logic    code_err;
    logic    rd_err;
    logic    error;
    logic    rd;
    logic    valid;

    `include "tb_ref_codec.svh"

    exp_t        exp_q[$];
    logic        enc_rd    = RD_NEG;  // encoder side
    logic        mdl_rd    = RD_NEG;  // decoder model at issue time
    logic [31:0] lcg_state = 32'he380;
    int          err_cnt   = 0;
    int          fail_cnt  = 0;
    int          n_checked = 0;
    int          cycles    = 0;

    always #5 clk = ~clk;

    dec_8b10b_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .symbol_in (symbol_in),
        .rd_load   (rd_load),
        .rd_init   (rd_init),
        .data_out  (data_out),
        .k_char    (k_char),
        .code_err  (code_err),
        .rd_err    (rd_err),
        .error     (error),
        .rd        (rd),
        .valid     (valid)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------
    // stimulus
    task automatic send_symbol(input symbol_t sym);
        exp_t e;
        e = exp_decode(sym, mdl_rd);
        @(posedge clk);
        enable    <= 1'b1;
        symbol_in <= sym;
        exp_q.push_back(e);
        mdl_rd = e.rd_next;
    endtask

    task automatic send_byte(input byte_t b, input logic k);
        logic [10:0] enc;
        enc    = enc_8b10b(b, k, enc_rd);
        enc_rd = enc[10];
        send_symbol(enc[9:0]);
    endtask

    task automatic send_random();
        lcg_state = lcg_next(lcg_state);
        send_byte(lcg_state[23:16], 1'b0);
    endtask

    task automatic send_wrong_rd(input byte_t b);
        logic [10:0] enc;
        enc = enc_8b10b(b, 1'b0, ~mdl_rd);
        send_symbol(enc[9:0]);
        enc_rd = mdl_rd;  // carry on from where the decoder lands
    endtask

    task automatic drain();
        @(posedge clk);
        enable <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic load_rd(input logic v);
        drain();
        @(posedge clk);
        rd_load <= 1'b1;
        rd_init <= v;
        @(posedge clk);
        rd_load <= 1'b0;
        mdl_rd = v;
        enc_rd = v;
    endtask

    // --------------------
    // scoreboard
    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] want);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
        err_cnt++;
    endtask

    task automatic check_outputs(input exp_t e);
        n_checked++;
        if (!e.code_err && data_out !== e.data) report_mismatch("data_out", data_out, e.data);
        if (k_char !== e.k) report_mismatch("k_char", k_char, e.k);
        if (code_err !== e.code_err) report_mismatch("code_err", code_err, e.code_err);
        if (rd_err !== e.rd_err) report_mismatch("rd_err", rd_err, e.rd_err);
        if (error !== (e.code_err | e.rd_err)) begin
            report_mismatch("error", error, e.code_err | e.rd_err);
        end
        if (rd !== e.rd_next) report_mismatch("rd", rd, e.rd_next);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (valid) begin
                if (exp_q.size() == 0) begin
                    $display("valid high at %0t with no symbol outstanding", $time);
                    fail_cnt++;
                end else begin
                    check_outputs(exp_q.pop_front());
                end
            end else begin
                if ({valid, data_out, k_char, code_err, rd_err, error} !== '0) begin
                    $display("outputs not quiet at %0t while valid is low", $time);
                    fail_cnt++;
                end
                if (exp_q.size() == 0 && rd !== mdl_rd) report_mismatch("rd", rd, mdl_rd);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, %0d symbols outstanding", cycles,
                     exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int i;
        int r;
        rst_n     = 1'b0;
        enable    = 1'b0;
        symbol_in = '0;
        rd_load   = 1'b0;
        rd_init   = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);  // idle with outputs low and rd-

        repeat (N_RANDOM) send_random();
        // --------------------
        // control characters at both disparities
        for (i = 0; i < 12; i++) begin
            for (r = 0; r < 2; r++) begin
                if (enc_rd != r[0]) send_byte(8'h20, 1'b0);  // D0.1 flips rd
                send_byte(K_BYTES[8*i +: 8], 1'b1);
            end
        end
        send_symbol({6'b000000, 4'b1001});
        send_symbol({6'b111111, 4'b0101});
        send_symbol({6'b110001, 4'b0000});
        send_symbol({6'b110001, 4'b1111});
        for (i = 0; i < 4; i++) begin
            send_wrong_rd(BAD_RD_BYTES[8*i +: 8]);
            send_random();
        end
        // --------------------
        // load rd+ and gaps
        if (enc_rd == RD_POS) send_byte(8'h20, 1'b0);
        load_rd(RD_POS);
        send_byte(8'h00, 1'b0);
        drain();
        repeat (4) @(posedge clk);
        send_random();
        drain();
        repeat (2) @(posedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d symbols issued but never decoded", exp_q.size());
            fail_cnt++;
        end
        $display("checked %0d symbols: %0d value errors, %0d other failures", n_checked,
                 err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+verification
design/dec_pkg.sv
design/dec_6b5b.sv
design/dec_4b3b.sv
design/symbol_stage.sv
design/disparity_check.sv
design/dec_8b10b_top.sv
verification/tb_dec_8b10b.sv

/* Bender.yml */
package:
  name: dec_8b10b

sources:
  - design/dec_pkg.sv
  - design/dec_6b5b.sv
  - design/dec_4b3b.sv
  - design/symbol_stage.sv
  - design/disparity_check.sv
  - design/dec_8b10b_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_dec_8b10b.sv
